//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_word
RTL_TOP   ?= uart_word_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^hw/' $(FILELIST))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS) hw/uart_consts.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	$(SIM) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall +incdir+hw $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+hw
hw/uart_pkg.sv
hw/apb_pkg.sv
hw/uart_rx.sv
hw/uart_word_asm.sv
hw/word_fifo.sv
hw/uart_apb_regs.sv
hw/uart_word_top.sv
tests/tb_uart_word.sv

//--- hw/apb_pkg.sv
`default_nettype none

package apb_pkg;

    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Slave side of one access, setup through completion
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_FETCH,
        APB_DONE
    } apb_state_e;

endpackage

`default_nettype wire

//--- hw/uart_apb_regs.sv
`default_nettype none

`include "uart_consts.svh"

module uart_apb_regs (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    psel,
    input  wire                                    penable,
    input  wire                                    pwrite,
    input  wire apb_pkg::apb_addr_t                paddr,
    input  wire apb_pkg::apb_data_t                pwdata,
    input  wire uart_pkg::word_t                   rd_word,
    input  wire [$clog2(`UART_FIFO_DEPTH+1)-1:0]   level,
    input  wire                                    overflow,
    input  wire                                    frame_err,
    input  wire uart_pkg::count_t                  word_count,
    output apb_pkg::apb_data_t                     prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic                                   pop,
    output logic                                   clear
);

    localparam int LVL_W = $clog2(`UART_FIFO_DEPTH + 1);

    apb_pkg::apb_state_e state;
    apb_pkg::apb_data_t rd_val;
    logic acc_err;
    logic access;
    logic frame_seen;

    assign access = (state == apb_pkg::APB_FETCH) && psel && penable;
    assign pready = (state == apb_pkg::APB_DONE);

    always_comb begin
        rd_val  = '0;
        acc_err = 1'b0;
        case (paddr)
            `UART_REG_DATA: begin
                rd_val  = apb_pkg::apb_data_t'(rd_word);
                acc_err = !pwrite && (level == '0); // Nothing to read
            end
            `UART_REG_STATUS: begin
                rd_val[0]          = (level != '0);
                rd_val[1]          = overflow;
                rd_val[2]          = frame_seen;
                rd_val[8 +: LVL_W] = level;
            end
            `UART_REG_COUNT: rd_val = apb_pkg::apb_data_t'(word_count);
            `UART_REG_CTRL:  rd_val = '0;
            default:         acc_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= apb_pkg::APB_IDLE;
            pslverr    <= 1'b0;
            pop        <= 1'b0;
            clear      <= 1'b0;
            frame_seen <= 1'b0;
        end else begin
            pop   <= access && !pwrite && (paddr == `UART_REG_DATA) && !acc_err;
            clear <= access && pwrite && (paddr == `UART_REG_CTRL) && pwdata[0];
            if (clear) begin
                frame_seen <= 1'b0;
            end else if (frame_err) begin
                frame_seen <= 1'b1;
            end
            case (state)
                apb_pkg::APB_IDLE: begin
                    if (psel && !penable) state <= apb_pkg::APB_FETCH;
                end
                apb_pkg::APB_FETCH: begin
                    if (access) begin
                        state   <= apb_pkg::APB_DONE;
                        pslverr <= acc_err;
                    end else if (!psel) begin
                        state <= apb_pkg::APB_IDLE;
                    end
                end
                apb_pkg::APB_DONE: begin
                    state   <= apb_pkg::APB_IDLE;
                    pslverr <= 1'b0;
                end
                default: state <= apb_pkg::APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (access) prdata <= rd_val;
    end

    assert property (@(posedge clk) disable iff (!rst) pready |-> psel && penable)
        else $error("uart_apb_regs: pready outside an access phase");

endmodule

`default_nettype wire

//--- hw/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Serial timing
`define UART_CLKS_PER_BIT 8

// Number of 16-bit words the receive FIFO can hold
`define UART_FIFO_DEPTH 8

// Register byte offsets on the APB port
`define UART_REG_DATA   12'h000
`define UART_REG_STATUS 12'h004
`define UART_REG_COUNT  12'h008
`define UART_REG_CTRL   12'h00C

`endif

//--- hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0] byte_t;   // One received character
    typedef logic [15:0] word_t;  // Two characters, low byte first
    typedef logic [15:0] count_t; // Number of finished words, wraps

    // Receiver frame position
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Which half of the word comes next
    typedef enum logic {
        ASM_LOW,
        ASM_HIGH
    } asm_state_e;

endpackage

`default_nettype wire

//--- hw/uart_rx.sv
`default_nettype none

`include "uart_consts.svh"

module uart_rx (
    input  wire             clk,
    input  wire             rst,
    input  wire             rxd,
    output logic            byte_valid,
    output uart_pkg::byte_t rx_byte,
    output logic            frame_err
);

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CPB - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CPB / 2 - 1);

    logic rxd_meta;
    logic rxd_sync;
    uart_pkg::rx_state_e state;
    logic [CNT_W-1:0] cnt;
    logic [2:0] bit_idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rxd_meta <= 1'b1; // Line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= uart_pkg::RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    cnt <= '0;
                    if (!rxd_sync) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (cnt == CNT_HALF) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // A start bit that is high again at mid-bit was a glitch
                        state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (cnt == CNT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (cnt == CNT_LAST) begin
                        cnt        <= '0;
                        byte_valid <= rxd_sync;  // Strobe lands mid stop bit
                        frame_err  <= !rxd_sync;
                        state      <= uart_pkg::RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && cnt == CNT_LAST) begin
            rx_byte <= {rxd_sync, rx_byte[7:1]};
        end
    end

    assert property (@(posedge clk) disable iff (!rst) !(byte_valid && frame_err))
        else $error("uart_rx: byte strobe and frame error in the same cycle");

endmodule

`default_nettype wire

//--- hw/uart_word_asm.sv
`default_nettype none

module uart_word_asm (
    input  wire              clk,
    input  wire              rst,
    input  wire              byte_valid,
    input  wire              uart_pkg::byte_t rx_byte,
    input  wire              clear,
    output logic             word_valid,
    output uart_pkg::word_t  word,
    output uart_pkg::count_t word_count
);

    uart_pkg::asm_state_e state;
    uart_pkg::byte_t low_byte;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= uart_pkg::ASM_LOW;
            word_valid <= 1'b0;
            word_count <= '0;
        end else begin
            word_valid <= 1'b0;
            if (clear) begin
                state      <= uart_pkg::ASM_LOW; // Drops a waiting low byte
                word_count <= '0;
            end else if (byte_valid) begin
                case (state)
                    uart_pkg::ASM_LOW: begin
                        state <= uart_pkg::ASM_HIGH;
                    end
                    uart_pkg::ASM_HIGH: begin
                        state      <= uart_pkg::ASM_LOW;
                        word_valid <= 1'b1;
                        word_count <= word_count + 1'b1; // Wraps at 16 bits
                    end
                    default: state <= uart_pkg::ASM_LOW;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (state == uart_pkg::ASM_LOW) begin
                low_byte <= rx_byte;
            end else begin
                word <= {rx_byte, low_byte};
            end
        end
    end

    // Two bytes are needed per word and each takes a whole frame
    assert property (@(posedge clk) disable iff (!rst) word_valid |=> !word_valid)
        else $error("uart_word_asm: word strobe in two consecutive cycles");

endmodule

`default_nettype wire

//--- hw/uart_word_top.sv
`default_nettype none

`include "uart_consts.svh"

module uart_word_top (
    input  wire                clk,
    input  wire                rst,
    input  wire                rxd,
    input  wire                psel,
    input  wire                penable,
    input  wire                pwrite,
    input  wire apb_pkg::apb_addr_t paddr,
    input  wire apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr
);

    logic byte_valid;
    logic frame_err;
    uart_pkg::byte_t rx_byte;
    logic word_valid;
    uart_pkg::word_t word;
    uart_pkg::count_t word_count;
    uart_pkg::word_t rd_word;
    logic [$clog2(`UART_FIFO_DEPTH+1)-1:0] level;
    logic overflow;
    logic pop;
    logic clear;

    uart_rx u_uart_rx (
        .clk        (clk),
        .rst        (rst),
        .rxd        (rxd),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .frame_err  (frame_err)
    );

    uart_word_asm u_uart_word_asm (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .clear      (clear),
        .word_valid (word_valid),
        .word       (word),
        .word_count (word_count)
    );

    word_fifo u_word_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (word_valid),
        .wr_word  (word),
        .pop      (pop),
        .clear    (clear),
        .rd_word  (rd_word),
        .level    (level),
        .overflow (overflow)
    );

    uart_apb_regs u_uart_apb_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .rd_word    (rd_word),
        .level      (level),
        .overflow   (overflow),
        .frame_err  (frame_err),
        .word_count (word_count),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .pop        (pop),
        .clear      (clear)
    );

endmodule

`default_nettype wire

//--- hw/word_fifo.sv
`default_nettype none

`include "uart_consts.svh"

module word_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push,
    input  wire uart_pkg::word_t         wr_word,
    input  wire                          pop,
    input  wire                          clear,
    output uart_pkg::word_t              rd_word,
    output logic [$clog2(DEPTH+1)-1:0]   level,
    output logic                         overflow
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int LVL_W = $clog2(DEPTH + 1);

    uart_pkg::word_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop  = pop && (level != '0);
    assign do_push = push && ((level != LVL_W'(DEPTH)) || do_pop); // Full but popping is fine
    assign rd_word = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else if (clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
            if (push && !do_push) overflow <= 1'b1; // Word is lost
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= wr_word;
    end

    assert property (@(posedge clk) disable iff (!rst) pop |-> level != '0)
        else $error("word_fifo: pop while empty");

endmodule

`default_nettype wire

//--- tests/tb_uart_word.sv
`default_nettype none

`include "uart_consts.svh"

module tb_uart_word;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int TIMEOUT_CYCLES = 20000; // About 6000 cycles of frames and bus traffic

    logic clk = 1'b0;
    logic rst;
    logic rxd;
    logic psel;
    logic penable;
    logic pwrite;
    apb_pkg::apb_addr_t paddr;
    apb_pkg::apb_data_t pwdata;
    apb_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;

    uart_pkg::word_t model_q[$]; // Words the FIFO should hold, oldest first
    logic model_ovf;
    logic model_frame;
    uart_pkg::count_t model_count;

    string name_q[$];
    apb_pkg::apb_data_t exp_data_q[$];
    logic exp_err_q[$];
    logic data_used_q[$];
    apb_pkg::apb_data_t act_data_q[$];
    logic act_err_q[$];

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    uart_word_top u_uart_word_top (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    // Low byte arrives first
    function automatic uart_pkg::word_t expected_word(input uart_pkg::byte_t lo,
                                                      input uart_pkg::byte_t hi);
        return {hi, lo};
    endfunction

    function automatic apb_pkg::apb_data_t expected_status();
        apb_pkg::apb_data_t s;
        s = '0;
        s[0] = (model_q.size() != 0);
        s[1] = model_ovf;
        s[2] = model_frame;
        s[8 +: 4] = 4'(model_q.size());
        return s;
    endfunction

    task automatic model_push(input uart_pkg::word_t w);
        model_count = model_count + 1'b1; // Counted even when the FIFO drops it
        if (model_q.size() < DEPTH) begin
            model_q.push_back(w);
        end else begin
            model_ovf = 1'b1;
        end
    endtask

    task automatic send_byte(input uart_pkg::byte_t data, input logic bad_stop);
        rxd = 1'b0;
        repeat (CPB) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            repeat (CPB) @(negedge clk);
        end
        rxd = !bad_stop;
        repeat (CPB) @(negedge clk);
        rxd = 1'b1;
    endtask

    task automatic send_word(input uart_pkg::byte_t lo, input uart_pkg::byte_t hi);
        send_byte(lo, 1'b0);
        send_byte(hi, 1'b0);
        repeat (2) @(negedge clk); // Word is readable 2 cycles after the stop bit
        model_push(expected_word(lo, hi));
    endtask

    task automatic apb_access(input logic write, input apb_pkg::apb_addr_t addr,
                              input apb_pkg::apb_data_t wdata);
        int waits;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!pready);
        act_data_q.push_back(prdata);
        act_err_q.push_back(pslverr);
        assert (waits == 1) else begin
            errors++;
            $display("APB access to offset %h did not finish in its second access cycle", addr);
        end
        @(negedge clk); // Access stays up through the completing edge
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_result(input string name, input apb_pkg::apb_data_t exp,
                                 input logic exp_err, input logic used);
        name_q.push_back(name);
        exp_data_q.push_back(exp);
        exp_err_q.push_back(exp_err);
        data_used_q.push_back(used);
    endtask

    task automatic read_reg(input string name, input apb_pkg::apb_addr_t addr,
                            input apb_pkg::apb_data_t exp, input logic exp_err, input logic used);
        expect_result(name, exp, exp_err, used);
        apb_access(1'b0, addr, '0);
    endtask

    task automatic write_reg(input string name, input apb_pkg::apb_addr_t addr,
                             input apb_pkg::apb_data_t data);
        expect_result(name, '0, 1'b0, 1'b0);
        apb_access(1'b1, addr, data);
    endtask

    task automatic read_word(input string name);
        uart_pkg::word_t w;
        w = model_q.pop_front();
        read_reg(name, `UART_REG_DATA, apb_pkg::apb_data_t'(w), 1'b0, 1'b1);
    endtask

    always @(posedge clk) begin : compare
        string name;
        apb_pkg::apb_data_t act;
        apb_pkg::apb_data_t exp;
        logic act_err;
        logic exp_err;
        logic used;
        while (act_data_q.size() != 0 && name_q.size() != 0) begin
            name = name_q.pop_front();
            exp = exp_data_q.pop_front();
            exp_err = exp_err_q.pop_front();
            used = data_used_q.pop_front();
            act = act_data_q.pop_front();
            act_err = act_err_q.pop_front();
            checks++;
            assert (act_err == exp_err) else begin
                errors++;
                $display("Error %s pslverr: expected %0b, actual %0b", name, exp_err, act_err);
            end
            assert (!used || act == exp) else begin
                errors++;
                $display("Error %s: expected %h, actual %h", name, exp, act);
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            assert (!pready || (psel && penable)) else begin
                errors++;
                $display("pready was high outside an APB access phase");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests finished", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    initial begin : main
        uart_pkg::byte_t lo;
        uart_pkg::byte_t hi;
        void'($urandom(27));
        rst = 1'b0;
        rxd = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        model_ovf = 1'b0;
        model_frame = 1'b0;
        model_count = '0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);

        // Groups of four keep the FIFO from filling
        for (int g = 0; g < 5; g++) begin
            for (int p = 0; p < 4; p++) begin
                lo = 8'($urandom());
                hi = 8'($urandom());
                send_word(lo, hi);
            end
            for (int p = 0; p < 4; p++) begin
                read_word($sformatf("random word %0d", g * 4 + p));
            end
        end
        read_reg("count after random words", `UART_REG_COUNT, 32'(model_count), 1'b0, 1'b1);
        read_reg("status after random words", `UART_REG_STATUS, expected_status(), 1'b0, 1'b1);

        for (int i = 0; i < DEPTH + 2; i++) begin
            lo = 8'($urandom());
            hi = 8'($urandom());
            send_word(lo, hi);
        end
        read_reg("status at overflow", `UART_REG_STATUS, expected_status(), 1'b0, 1'b1);
        for (int i = 0; i < DEPTH; i++) begin
            read_word($sformatf("kept word %0d", i));
        end
        read_reg("count with dropped words", `UART_REG_COUNT, 32'(model_count), 1'b0, 1'b1);

        send_byte(8'hA5, 1'b1);
        repeat (2 * CPB) @(negedge clk); // Idle line so the receiver drops the false start
        model_frame = 1'b1;
        send_word(8'h3C, 8'hC3);
        read_reg("status after frame error", `UART_REG_STATUS, expected_status(), 1'b0, 1'b1);
        read_word("word after frame error");
        read_reg("count after frame error", `UART_REG_COUNT, 32'(model_count), 1'b0, 1'b1);

        send_word(8'h66, 8'h77); // Left in the FIFO for the clear to drop
        send_byte(8'h11, 1'b0);
        repeat (2) @(negedge clk);
        write_reg("clear", `UART_REG_CTRL, 32'd1);
        model_q.delete();
        model_ovf = 1'b0;
        model_frame = 1'b0;
        model_count = '0;
        read_reg("count after clear", `UART_REG_COUNT, 32'(model_count), 1'b0, 1'b1);
        read_reg("status after clear", `UART_REG_STATUS, expected_status(), 1'b0, 1'b1);
        send_word(8'h22, 8'h33);
        read_word("word after clear");

        read_reg("data read while empty", `UART_REG_DATA, '0, 1'b1, 1'b0);
        send_word(8'h44, 8'h55);
        read_reg("unmapped offset", 12'h010, '0, 1'b1, 1'b0);
        read_reg("status after error reads", `UART_REG_STATUS, expected_status(), 1'b0, 1'b1);
        read_reg("count after error reads", `UART_REG_COUNT, 32'(model_count), 1'b0, 1'b1);
        read_word("word after error reads");

        repeat (2) @(negedge clk);
        assert (name_q.size() == 0) else begin
            errors++;
            $display("%0d expected bus results were never compared", name_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
